// File: design/clus_pkg.sv
package clus_pkg;

    // Client side
    localparam int NUM_CLIENTS     = 3;
    localparam int CLIENT_IDX_BITS = 2;
    localparam int CLIENT_TAG_BITS = 8;

    // Memory side
    localparam int DATA_BITS   = 64;
    localparam int ADDR_BITS   = 26;
    localparam int BYTEEN_BITS = DATA_BITS / 8;

    // Client index goes in above bit 0, which is the NC flag
    localparam int TAG_SEL_IDX  = 1;
    localparam int MEM_TAG_BITS = CLIENT_TAG_BITS + CLIENT_IDX_BITS;

    // Flattened payloads through the elastic buffers
    localparam int REQ_BITS = 1 + ADDR_BITS + DATA_BITS + BYTEEN_BITS + MEM_TAG_BITS;
    localparam int RSP_BITS = DATA_BITS + MEM_TAG_BITS;

    typedef logic [DATA_BITS-1:0]       data_t;
    typedef logic [ADDR_BITS-1:0]       addr_t;
    typedef logic [BYTEEN_BITS-1:0]     byteen_t;
    typedef logic [CLIENT_TAG_BITS-1:0] client_tag_t;
    typedef logic [MEM_TAG_BITS-1:0]    mem_tag_t;
    typedef logic [CLIENT_IDX_BITS-1:0] client_idx_t;

endpackage

// File: design/clus_mem_req_if.sv
`timescale 1ns/1ps

interface clus_mem_req_if;

    logic                  valid;
    logic                  rw;
    clus_pkg::addr_t       addr;
    clus_pkg::data_t       data;
    clus_pkg::byteen_t     byteen;
    clus_pkg::mem_tag_t    tag;
    logic                  ready;

    modport source (
        output valid,
        output rw,
        output addr,
        output data,
        output byteen,
        output tag,
        input  ready
    );

    modport sink (
        input  valid,
        input  rw,
        input  addr,
        input  data,
        input  byteen,
        input  tag,
        output ready
    );

endinterface

// File: design/clus_mem_rsp_if.sv
`timescale 1ns/1ps

interface clus_mem_rsp_if;

    logic                  valid;
    clus_pkg::data_t       data;
    clus_pkg::mem_tag_t    tag;
    logic                  ready;

    modport source (
        output valid,
        output data,
        output tag,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  tag,
        output ready
    );

endinterface

// File: design/clus_elastic_buf.sv
`timescale 1ns/1ps

module clus_elastic_buf #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  logic [WIDTH-1:0] in_data,
    output logic             in_ready,
    output logic             out_valid,
    output logic [WIDTH-1:0] out_data,
    input  logic             out_ready
);

    logic             head_valid_q;
    logic [WIDTH-1:0] head_data_q;
    logic             skid_valid_q;
    logic [WIDTH-1:0] skid_data_q;
    logic             ready_q;

    logic             head_valid_n;
    logic [WIDTH-1:0] head_data_n;
    logic             skid_valid_n;
    logic [WIDTH-1:0] skid_data_n;
    logic             in_fire;

    assign in_fire = in_valid && ready_q;

    always_comb begin
        head_valid_n = head_valid_q;
        head_data_n  = head_data_q;
        skid_valid_n = skid_valid_q;
        skid_data_n  = skid_data_q;
        if (!head_valid_q || out_ready) begin
            // Head is free or leaving, older skid entry moves up first
            if (skid_valid_q) begin
                head_valid_n = 1'b1;
                head_data_n  = skid_data_q;
                skid_valid_n = in_fire;
                skid_data_n  = in_data;
            end else begin
                head_valid_n = in_fire;
                head_data_n  = in_data;
            end
        end else if (in_fire) begin
            skid_valid_n = 1'b1;
            skid_data_n  = in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_valid_q <= 1'b0;
            skid_valid_q <= 1'b0;
            ready_q      <= 1'b0;
        end else begin
            head_valid_q <= head_valid_n;
            skid_valid_q <= skid_valid_n;
            // Skid is only occupied when head is too
            ready_q      <= !skid_valid_n;
        end
    end

    always_ff @(posedge clk) begin
        head_data_q <= head_data_n;
        skid_data_q <= skid_data_n;
    end

    assign in_ready  = ready_q;
    assign out_valid = head_valid_q;
    assign out_data  = head_data_q;

    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: design/clus_req_arb.sv
`timescale 1ns/1ps

module clus_req_arb (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic [clus_pkg::NUM_CLIENTS-1:0]                       client_req_valid,
    input  logic [clus_pkg::NUM_CLIENTS-1:0]                       client_req_rw,
    input  clus_pkg::addr_t [clus_pkg::NUM_CLIENTS-1:0]            client_req_addr,
    input  clus_pkg::data_t [clus_pkg::NUM_CLIENTS-1:0]            client_req_data,
    input  clus_pkg::byteen_t [clus_pkg::NUM_CLIENTS-1:0]          client_req_byteen,
    input  clus_pkg::client_tag_t [clus_pkg::NUM_CLIENTS-1:0]      client_req_tag,
    output logic [clus_pkg::NUM_CLIENTS-1:0]                       client_req_ready,
    clus_mem_req_if.source                                         arb_req
);

    localparam int N   = clus_pkg::NUM_CLIENTS;
    localparam int SEL = clus_pkg::TAG_SEL_IDX;

    clus_pkg::client_idx_t prio_ptr;
    clus_pkg::client_idx_t gnt_idx;
    clus_pkg::client_tag_t gnt_tag;
    logic [N-1:0]          rr_grant;
    logic [N-1:0]          grant;
    logic [N-1:0]          lock_grant_q;
    logic                  lock_q;
    logic                  xfer;

    // Lowest offset from the pointer wins
    function automatic logic [N-1:0] rr_pick(input logic [N-1:0] req,
                                             input clus_pkg::client_idx_t ptr);
        logic [N-1:0] pick;
        int           idx;
        pick = '0;
        for (int k = N - 1; k >= 0; k--) begin
            idx = (int'(ptr) + k) % N;
            if (req[idx]) begin
                pick      = '0;
                pick[idx] = 1'b1;
            end
        end
        return pick;
    endfunction

    assign rr_grant = rr_pick(client_req_valid, prio_ptr);

    // A stalled request keeps its grant so the payload holds
    assign grant = lock_q ? lock_grant_q : rr_grant;

    always_comb begin
        gnt_idx = '0;
        for (int i = 0; i < N; i++) begin
            if (grant[i]) begin
                gnt_idx = clus_pkg::client_idx_t'(i);
            end
        end
    end

    assign gnt_tag = client_req_tag[gnt_idx];

    assign arb_req.valid  = |(grant & client_req_valid);
    assign arb_req.rw     = client_req_rw[gnt_idx];
    assign arb_req.addr   = client_req_addr[gnt_idx];
    assign arb_req.data   = client_req_data[gnt_idx];
    assign arb_req.byteen = client_req_byteen[gnt_idx];
    assign arb_req.tag    = {gnt_tag[clus_pkg::CLIENT_TAG_BITS-1:SEL], gnt_idx,
                             gnt_tag[SEL-1:0]};

    assign client_req_ready = grant & {N{arb_req.ready}};

    assign xfer = arb_req.valid && arb_req.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            prio_ptr <= '0;
            lock_q   <= 1'b0;
        end else begin
            lock_q <= arb_req.valid && !arb_req.ready;
            if (xfer) begin
                prio_ptr <= (gnt_idx == clus_pkg::client_idx_t'(N - 1)) ?
                            '0 : gnt_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        lock_grant_q <= grant;
    end

    // A client just served yields to any client left waiting
    a_grant_rotate: assert property (@(posedge clk) disable iff (rst)
        xfer && |(client_req_valid & ~grant) |=> !(|(grant & $past(grant))));

    // Clients must hold their request until it is taken
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        arb_req.valid && !arb_req.ready |=> arb_req.valid && $stable(arb_req.tag));

endmodule

// File: design/clus_rsp_route.sv
`timescale 1ns/1ps

module clus_rsp_route (
    input  logic                                              clk,
    clus_mem_rsp_if.sink                                      route_rsp,
    output logic [clus_pkg::NUM_CLIENTS-1:0]                  client_rsp_valid,
    output clus_pkg::data_t [clus_pkg::NUM_CLIENTS-1:0]       client_rsp_data,
    output clus_pkg::client_tag_t [clus_pkg::NUM_CLIENTS-1:0] client_rsp_tag,
    input  logic [clus_pkg::NUM_CLIENTS-1:0]                  client_rsp_ready
);

    localparam int N   = clus_pkg::NUM_CLIENTS;
    localparam int SEL = clus_pkg::TAG_SEL_IDX;
    localparam int HI  = SEL + clus_pkg::CLIENT_IDX_BITS;

    clus_pkg::client_idx_t rsp_idx;
    clus_pkg::client_tag_t rsp_tag;
    logic [N-1:0]          sel;

    assign rsp_idx = route_rsp.tag[HI-1:SEL];

    // Undo the index insertion, NC flag stays in bit 0
    assign rsp_tag = {route_rsp.tag[clus_pkg::MEM_TAG_BITS-1:HI], route_rsp.tag[SEL-1:0]};

    for (genvar i = 0; i < N; i++) begin : g_client
        assign sel[i]              = (rsp_idx == clus_pkg::client_idx_t'(i));
        assign client_rsp_valid[i] = route_rsp.valid && sel[i];
        assign client_rsp_data[i]  = route_rsp.data;
        assign client_rsp_tag[i]   = rsp_tag;
    end

    assign route_rsp.ready = |(sel & client_rsp_ready);

    a_idx_range: assert property (@(posedge clk)
        route_rsp.valid |-> (int'(rsp_idx) < N));

endmodule

// File: design/clus_mem_mux.sv
`timescale 1ns/1ps

module clus_mem_mux (
    input  logic                                              clk,
    input  logic                                              rst,

    // Client requests
    input  logic [clus_pkg::NUM_CLIENTS-1:0]                  client_req_valid,
    input  logic [clus_pkg::NUM_CLIENTS-1:0]                  client_req_rw,
    input  clus_pkg::addr_t [clus_pkg::NUM_CLIENTS-1:0]       client_req_addr,
    input  clus_pkg::data_t [clus_pkg::NUM_CLIENTS-1:0]       client_req_data,
    input  clus_pkg::byteen_t [clus_pkg::NUM_CLIENTS-1:0]     client_req_byteen,
    input  clus_pkg::client_tag_t [clus_pkg::NUM_CLIENTS-1:0] client_req_tag,
    output logic [clus_pkg::NUM_CLIENTS-1:0]                  client_req_ready,

    // Client responses
    output logic [clus_pkg::NUM_CLIENTS-1:0]                  client_rsp_valid,
    output clus_pkg::data_t [clus_pkg::NUM_CLIENTS-1:0]       client_rsp_data,
    output clus_pkg::client_tag_t [clus_pkg::NUM_CLIENTS-1:0] client_rsp_tag,
    input  logic [clus_pkg::NUM_CLIENTS-1:0]                  client_rsp_ready,

    // Memory
    output logic                                              mem_req_valid,
    output logic                                              mem_req_rw,
    output clus_pkg::addr_t                                   mem_req_addr,
    output clus_pkg::data_t                                   mem_req_data,
    output clus_pkg::byteen_t                                 mem_req_byteen,
    output clus_pkg::mem_tag_t                                mem_req_tag,
    input  logic                                              mem_req_ready,
    input  logic                                              mem_rsp_valid,
    input  clus_pkg::data_t                                   mem_rsp_data,
    input  clus_pkg::mem_tag_t                                mem_rsp_tag,
    output logic                                              mem_rsp_ready
);

    clus_mem_req_if arb_req ();
    clus_mem_rsp_if route_rsp ();

    logic [clus_pkg::REQ_BITS-1:0] req_in_data;
    logic [clus_pkg::REQ_BITS-1:0] req_out_data;
    logic [clus_pkg::RSP_BITS-1:0] rsp_in_data;
    logic [clus_pkg::RSP_BITS-1:0] rsp_out_data;

    clus_req_arb u_req_arb (
        .clk               (clk),
        .rst               (rst),
        .client_req_valid  (client_req_valid),
        .client_req_rw     (client_req_rw),
        .client_req_addr   (client_req_addr),
        .client_req_data   (client_req_data),
        .client_req_byteen (client_req_byteen),
        .client_req_tag    (client_req_tag),
        .client_req_ready  (client_req_ready),
        .arb_req           (arb_req.source)
    );

    assign req_in_data = {arb_req.rw, arb_req.addr, arb_req.data, arb_req.byteen, arb_req.tag};

    clus_elastic_buf #(
        .WIDTH (clus_pkg::REQ_BITS)
    ) u_req_buf (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (arb_req.valid),
        .in_data   (req_in_data),
        .in_ready  (arb_req.ready),
        .out_valid (mem_req_valid),
        .out_data  (req_out_data),
        .out_ready (mem_req_ready)
    );

    assign {mem_req_rw, mem_req_addr, mem_req_data, mem_req_byteen, mem_req_tag} = req_out_data;

    assign rsp_in_data = {mem_rsp_data, mem_rsp_tag};

    clus_elastic_buf #(
        .WIDTH (clus_pkg::RSP_BITS)
    ) u_rsp_buf (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (mem_rsp_valid),
        .in_data   (rsp_in_data),
        .in_ready  (mem_rsp_ready),
        .out_valid (route_rsp.valid),
        .out_data  (rsp_out_data),
        .out_ready (route_rsp.ready)
    );

    assign {route_rsp.data, route_rsp.tag} = rsp_out_data;

    clus_rsp_route u_rsp_route (
        .clk              (clk),
        .route_rsp        (route_rsp.sink),
        .client_rsp_valid (client_rsp_valid),
        .client_rsp_data  (client_rsp_data),
        .client_rsp_tag   (client_rsp_tag),
        .client_rsp_ready (client_rsp_ready)
    );

endmodule

// File: verification/tb_clus_mem_mux.sv
`timescale 1ns/1ps

module tb_clus_mem_mux;

    localparam int N            = clus_pkg::NUM_CLIENTS;
    localparam int REQS         = 200;
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 10;
    localparam int POOL_DEPTH   = 64;
    // 40 cycles per request over all clients
    localparam int WATCHDOG_NS  = N * REQS * 40 * CLK_PERIOD;

    logic                                      clk;
    logic                                      rst;
    logic [N-1:0]                              client_req_valid;
    logic [N-1:0]                              client_req_rw;
    clus_pkg::addr_t [N-1:0]                   client_req_addr;
    clus_pkg::data_t [N-1:0]                   client_req_data;
    clus_pkg::byteen_t [N-1:0]                 client_req_byteen;
    clus_pkg::client_tag_t [N-1:0]             client_req_tag;
    logic [N-1:0]                              client_req_ready;
    logic [N-1:0]                              client_rsp_valid;
    clus_pkg::data_t [N-1:0]                   client_rsp_data;
    clus_pkg::client_tag_t [N-1:0]             client_rsp_tag;
    logic [N-1:0]                              client_rsp_ready;
    logic                                      mem_req_valid;
    logic                                      mem_req_rw;
    clus_pkg::addr_t                           mem_req_addr;
    clus_pkg::data_t                           mem_req_data;
    clus_pkg::byteen_t                         mem_req_byteen;
    clus_pkg::mem_tag_t                        mem_req_tag;
    logic                                      mem_req_ready;
    logic                                      mem_rsp_valid;
    clus_pkg::data_t                           mem_rsp_data;
    clus_pkg::mem_tag_t                        mem_rsp_tag;
    logic                                      mem_rsp_ready;

    integer seed;
    int     check_err_cnt;
    int     other_err_cnt;

    // Issued requests per client, in issue order
    logic                  req_rw     [N][REQS];
    clus_pkg::addr_t       req_addr   [N][REQS];
    clus_pkg::data_t       req_data   [N][REQS];
    clus_pkg::byteen_t     req_byteen [N][REQS];
    clus_pkg::client_tag_t req_tag    [N][REQS];
    int                    issued     [N];
    int                    accepted   [N];
    int                    forwarded  [N];
    int                    gap        [N];
    int                    wait_cnt   [N];
    logic [N-1:0]          req_fire;

    // Expected responses per client, in memory acceptance order
    clus_pkg::client_tag_t exp_rsp_tag  [N][REQS];
    clus_pkg::data_t       exp_rsp_data [N][REQS];
    int                    rsp_sent     [N];
    int                    rsp_got      [N];

    // Memory responder
    clus_pkg::mem_tag_t    pool_tag    [POOL_DEPTH];
    clus_pkg::data_t       pool_data   [POOL_DEPTH];
    int                    pool_client [POOL_DEPTH];
    clus_pkg::client_tag_t pool_ctag   [POOL_DEPTH];
    int                    pool_cnt;
    logic                  mem_rsp_fire;
    int                    mem_rsp_client;
    clus_pkg::client_tag_t mem_rsp_ctag;

    // Outputs seen during a stall
    logic                  req_stall_q;
    logic                  held_rw;
    clus_pkg::addr_t       held_addr;
    clus_pkg::data_t       held_data;
    clus_pkg::byteen_t     held_byteen;
    clus_pkg::mem_tag_t    held_tag;
    logic [N-1:0]          rsp_stall_q;
    clus_pkg::client_tag_t held_rsp_tag  [N];
    clus_pkg::data_t       held_rsp_data [N];

    clus_mem_mux u_clus_mem_mux (
        .clk               (clk),
        .rst               (rst),
        .client_req_valid  (client_req_valid),
        .client_req_rw     (client_req_rw),
        .client_req_addr   (client_req_addr),
        .client_req_data   (client_req_data),
        .client_req_byteen (client_req_byteen),
        .client_req_tag    (client_req_tag),
        .client_req_ready  (client_req_ready),
        .client_rsp_valid  (client_rsp_valid),
        .client_rsp_data   (client_rsp_data),
        .client_rsp_tag    (client_rsp_tag),
        .client_rsp_ready  (client_rsp_ready),
        .mem_req_valid     (mem_req_valid),
        .mem_req_rw        (mem_req_rw),
        .mem_req_addr      (mem_req_addr),
        .mem_req_data      (mem_req_data),
        .mem_req_byteen    (mem_req_byteen),
        .mem_req_tag       (mem_req_tag),
        .mem_req_ready     (mem_req_ready),
        .mem_rsp_valid     (mem_rsp_valid),
        .mem_rsp_data      (mem_rsp_data),
        .mem_rsp_tag       (mem_rsp_tag),
        .mem_rsp_ready     (mem_rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Response data the memory returns for a given request
    function automatic clus_pkg::data_t rsp_data_of(input clus_pkg::addr_t addr,
                                                    input clus_pkg::mem_tag_t tag);
        return {tag, 2'b01, addr, addr} ^ 64'h5a5a_0000_0000_a5a5;
    endfunction

    task automatic report_mismatch(input string sig, input string exp_s, input string act_s,
                                   input string ctx);
        $display("CHECK FAILED time %0t: %s expected %s actual %s (%s)",
                 $time, sig, exp_s, act_s, ctx);
        check_err_cnt++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR time %0t: %s", $time, msg);
        other_err_cnt++;
    endtask

    task automatic check_flag(input string sig, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            report_mismatch(sig, $sformatf("%b", exp_val), $sformatf("%b", act_val), "flag");
        end
    endtask

    task automatic check_req(input string ctx,
                             input logic exp_rw, input logic act_rw,
                             input clus_pkg::addr_t exp_addr, input clus_pkg::addr_t act_addr,
                             input clus_pkg::data_t exp_data, input clus_pkg::data_t act_data,
                             input clus_pkg::byteen_t exp_be, input clus_pkg::byteen_t act_be,
                             input clus_pkg::mem_tag_t exp_tag, input clus_pkg::mem_tag_t act_tag);
        if (act_rw !== exp_rw) begin
            report_mismatch("mem_req_rw", $sformatf("%b", exp_rw), $sformatf("%b", act_rw), ctx);
        end
        if (act_addr !== exp_addr) begin
            report_mismatch("mem_req_addr", $sformatf("%h", exp_addr),
                            $sformatf("%h", act_addr), ctx);
        end
        if (act_data !== exp_data) begin
            report_mismatch("mem_req_data", $sformatf("%h", exp_data),
                            $sformatf("%h", act_data), ctx);
        end
        if (act_be !== exp_be) begin
            report_mismatch("mem_req_byteen", $sformatf("%h", exp_be), $sformatf("%h", act_be), ctx);
        end
        if (act_tag !== exp_tag) begin
            report_mismatch("mem_req_tag", $sformatf("%h", exp_tag), $sformatf("%h", act_tag), ctx);
        end
    endtask

    task automatic check_rsp(input string ctx, input int c,
                             input clus_pkg::client_tag_t exp_tag,
                             input clus_pkg::client_tag_t act_tag,
                             input clus_pkg::data_t exp_data, input clus_pkg::data_t act_data);
        if (act_tag !== exp_tag) begin
            report_mismatch($sformatf("client_rsp_tag[%0d]", c), $sformatf("%h", exp_tag),
                            $sformatf("%h", act_tag), ctx);
        end
        if (act_data !== exp_data) begin
            report_mismatch($sformatf("client_rsp_data[%0d]", c), $sformatf("%h", exp_data),
                            $sformatf("%h", act_data), ctx);
        end
    endtask

    task automatic check_outputs_idle();
        check_flag("mem_req_valid", 1'b0, mem_req_valid);
        check_flag("mem_rsp_ready", 1'b0, mem_rsp_ready);
        for (int i = 0; i < N; i++) begin
            check_flag($sformatf("client_req_ready[%0d]", i), 1'b0, client_req_ready[i]);
            check_flag($sformatf("client_rsp_valid[%0d]", i), 1'b0, client_rsp_valid[i]);
        end
    endtask

    task automatic issue_request(input int c);
        int k;
        k = issued[c];
        req_rw[c][k]      = $random(seed) & 1;
        req_addr[c][k]    = clus_pkg::addr_t'($random(seed));
        req_data[c][k]    = {$random(seed), $random(seed)};
        req_byteen[c][k]  = clus_pkg::byteen_t'($random(seed));
        req_tag[c][k]     = clus_pkg::client_tag_t'(k);
        client_req_rw[c]     = req_rw[c][k];
        client_req_addr[c]   = req_addr[c][k];
        client_req_data[c]   = req_data[c][k];
        client_req_byteen[c] = req_byteen[c][k];
        client_req_tag[c]    = req_tag[c][k];
        client_req_valid[c]  = 1'b1;
        issued[c]++;
    endtask

    task automatic drive_cycle();
        int j;
        for (int i = 0; i < N; i++) begin
            if (req_fire[i]) begin
                client_req_valid[i] = 1'b0;
                gap[i] = int'($unsigned($random(seed)) % 4);
            end
            if (!client_req_valid[i] && issued[i] < REQS) begin
                if (gap[i] == 0) begin
                    issue_request(i);
                end else begin
                    gap[i]--;
                end
            end
            client_rsp_ready[i] = $random(seed) & 1;
        end
        mem_req_ready = (($random(seed) & 1) != 0) && (pool_cnt < POOL_DEPTH - 4);
        if (mem_rsp_fire) begin
            mem_rsp_valid = 1'b0;
        end
        // Pick any outstanding request, so responses come back out of order
        if (!mem_rsp_valid && pool_cnt > 0 && (($random(seed) & 1) != 0)) begin
            j = int'($unsigned($random(seed)) % pool_cnt);
            mem_rsp_tag    = pool_tag[j];
            mem_rsp_data   = pool_data[j];
            mem_rsp_client = pool_client[j];
            mem_rsp_ctag   = pool_ctag[j];
            mem_rsp_valid  = 1'b1;
            pool_tag[j]    = pool_tag[pool_cnt-1];
            pool_data[j]   = pool_data[pool_cnt-1];
            pool_client[j] = pool_client[pool_cnt-1];
            pool_ctag[j]   = pool_ctag[pool_cnt-1];
            pool_cnt--;
        end
    endtask

    task automatic sample_cycle();
        int                 c;
        int                 k;
        clus_pkg::mem_tag_t t;
        if (req_stall_q) begin
            check_flag("mem_req_valid", 1'b1, mem_req_valid);
            check_req("held under stall", held_rw, mem_req_rw, held_addr, mem_req_addr,
                      held_data, mem_req_data, held_byteen, mem_req_byteen, held_tag, mem_req_tag);
        end
        req_stall_q = mem_req_valid && !mem_req_ready;
        held_rw     = mem_req_rw;
        held_addr   = mem_req_addr;
        held_data   = mem_req_data;
        held_byteen = mem_req_byteen;
        held_tag    = mem_req_tag;
        for (int i = 0; i < N; i++) begin
            if (rsp_stall_q[i]) begin
                check_flag($sformatf("client_rsp_valid[%0d]", i), 1'b1, client_rsp_valid[i]);
                check_rsp("held under stall", i, held_rsp_tag[i], client_rsp_tag[i],
                          held_rsp_data[i], client_rsp_data[i]);
            end
            rsp_stall_q[i]   = client_rsp_valid[i] && !client_rsp_ready[i];
            held_rsp_tag[i]  = client_rsp_tag[i];
            held_rsp_data[i] = client_rsp_data[i];
        end

        // Round robin over three clients lets at most two others go first
        req_fire = client_req_valid & client_req_ready;
        for (int i = 0; i < N; i++) begin
            if (req_fire[i]) begin
                accepted[i]++;
                wait_cnt[i] = 0;
            end else if (client_req_valid[i]) begin
                wait_cnt[i] += $countones(req_fire);
                if (wait_cnt[i] > N - 1) begin
                    report_error($sformatf("client %0d waited behind %0d other requests",
                                           i, wait_cnt[i]));
                end
            end else begin
                wait_cnt[i] = 0;
            end
        end

        if ($countones(client_rsp_valid) > 1) begin
            report_error("more than one client response valid at once");
        end
        for (int i = 0; i < N; i++) begin
            if (client_rsp_valid[i] && client_rsp_ready[i]) begin
                if (rsp_got[i] >= rsp_sent[i]) begin
                    report_error($sformatf("client %0d got a response it never asked for", i));
                end else begin
                    check_rsp("response", i, exp_rsp_tag[i][rsp_got[i]], client_rsp_tag[i],
                              exp_rsp_data[i][rsp_got[i]], client_rsp_data[i]);
                    rsp_got[i]++;
                end
            end
        end

        if (mem_req_valid && mem_req_ready) begin
            c = int'(mem_req_tag[2:1]);
            if (c >= N) begin
                report_error($sformatf("memory request tag %h names no client", mem_req_tag));
            end else if (forwarded[c] >= accepted[c]) begin
                report_error($sformatf("memory request for client %0d with none pending", c));
            end else begin
                k = forwarded[c];
                t = {req_tag[c][k][7:1], clus_pkg::client_idx_t'(c), req_tag[c][k][0]};
                check_req("forwarded request", req_rw[c][k], mem_req_rw, req_addr[c][k],
                          mem_req_addr, req_data[c][k], mem_req_data, req_byteen[c][k],
                          mem_req_byteen, t, mem_req_tag);
                forwarded[c]++;
                pool_tag[pool_cnt]    = t;
                pool_data[pool_cnt]   = rsp_data_of(req_addr[c][k], t);
                pool_client[pool_cnt] = c;
                pool_ctag[pool_cnt]   = req_tag[c][k];
                pool_cnt++;
            end
        end

        mem_rsp_fire = mem_rsp_valid && mem_rsp_ready;
        if (mem_rsp_fire) begin
            c = mem_rsp_client;
            exp_rsp_tag[c][rsp_sent[c]]  = mem_rsp_ctag;
            exp_rsp_data[c][rsp_sent[c]] = mem_rsp_data;
            rsp_sent[c]++;
        end
    endtask

    function automatic logic all_done();
        logic done;
        done = 1'b1;
        for (int i = 0; i < N; i++) begin
            if (rsp_got[i] < REQS) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before all responses came back", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        seed              = 32'h8c7e_d5e2;
        check_err_cnt     = 0;
        other_err_cnt     = 0;
        rst               = 1'b1;
        client_req_valid  = '0;
        client_req_rw     = '0;
        client_req_addr   = '0;
        client_req_data   = '0;
        client_req_byteen = '0;
        client_req_tag    = '0;
        client_rsp_ready  = '0;
        mem_req_ready     = 1'b0;
        mem_rsp_valid     = 1'b0;
        mem_rsp_data      = '0;
        mem_rsp_tag       = '0;
        mem_rsp_client    = 0;
        mem_rsp_ctag      = '0;
        req_fire          = '0;
        mem_rsp_fire      = 1'b0;
        req_stall_q       = 1'b0;
        rsp_stall_q       = '0;
        pool_cnt          = 0;
        for (int i = 0; i < N; i++) begin
            issued[i]    = 0;
            accepted[i]  = 0;
            forwarded[i] = 0;
            gap[i]       = 0;
            wait_cnt[i]  = 0;
            rsp_sent[i]  = 0;
            rsp_got[i]   = 0;
        end

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_outputs_idle();
        @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        @(negedge clk);
        check_outputs_idle();
        @(negedge clk);
        check_flag("mem_rsp_ready", 1'b1, mem_rsp_ready);

        while (!all_done()) begin
            @(posedge clk);
            #DRIVE_DELAY;
            drive_cycle();
            @(negedge clk);
            sample_cycle();
        end

        $display("Requests %0d, check failures %0d, other errors %0d",
                 N * REQS, check_err_cnt, other_err_cnt);
        if (check_err_cnt == 0 && other_err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: clus_mem_mux.f
design/clus_pkg.sv
design/clus_mem_req_if.sv
design/clus_mem_rsp_if.sv
design/clus_elastic_buf.sv
design/clus_req_arb.sv
design/clus_rsp_route.sv
design/clus_mem_mux.sv
verification/tb_clus_mem_mux.sv
